//--- files.f
hdl/wb_pkg.sv
hdl/fir_map_pkg.sv
hdl/mem_region_map.sv
hdl/mem_req_bridge.sv
hdl/cpu_addr_router.sv
hdl/fir_bus_interconnect.sv
tests/fir_bus_properties.sv
tests/tb_fir_bus_interconnect.sv

//--- Bender.yml
package:
  name: fir_bus_interconnect

sources:
  - files:
      - hdl/wb_pkg.sv
      - hdl/fir_map_pkg.sv
      - hdl/mem_region_map.sv
      - hdl/mem_req_bridge.sv
      - hdl/cpu_addr_router.sv
      - hdl/fir_bus_interconnect.sv
  - target: test
    files:
      - tests/fir_bus_properties.sv
      - tests/tb_fir_bus_interconnect.sv

//--- tests/fir_bus_golden.txt
# op cpu_adr wdata target mem_addr rdata, all hex; rdata checked on reads, status and unmapped
# target 0 none, 1 dma1, 2 dma2, 3 status, 4 ram; mem_addr checked for ram only
W 38000000 11110000 4 000000 00000000
W 38000004 11110004 4 000004 00000000
W 38000308 11110308 4 000008 00000000
W 38000C1C 11110C1C 4 000C1C 00000000
W 38001000 22220000 4 001100 00000000
W 38001204 22221204 4 001104 00000000
W 38001310 22221310 4 001110 00000000
W 38001834 22221834 4 001934 00000000
W 38002000 33330000 4 002200 00000000
W 38002108 33332108 4 002208 00000000
W 3800233C 3333233C 4 00223C 00000000
W 38002FF8 33332FF8 4 002EF8 00000000
R 38000000 00000000 4 000000 11110000
R 38000308 00000000 4 000008 11110308
R 38000C1C 00000000 4 000C1C 11110C1C
R 38001204 00000000 4 001104 22221204
R 38001834 00000000 4 001934 22221834
R 38002108 00000000 4 002208 33332108
R 38002FF8 00000000 4 002EF8 33332FF8
R 38001000 00000000 4 001100 22220000
R 3800233C 00000000 4 00223C 3333233C
R 38000004 00000000 4 000004 11110004
W 38001310 AABBCCDD 4 001110 00000000
R 38001310 00000000 4 001110 AABBCCDD
W 38002000 0F0F0F0F 4 002200 00000000
R 38002000 00000000 4 002200 0F0F0F0F
W 38003000 12345678 1 000000 00000000
R 38003000 00000000 1 000000 C7003000
W 38003004 CAFEF00D 1 000000 00000000
R 38003004 00000000 1 000000 C7003004
W 38003008 00001000 2 000000 00000000
R 38003008 00000000 2 000000 C7003008
W 3800300C 00000040 2 000000 00000000
R 3800300C 00000000 2 000000 C700300C
R 38003010 00000000 3 000000 E0F10003
W 38003010 FFFFFFFF 3 000000 00000000
R 38003010 00000000 3 000000 E0F10003
R 38003020 00000000 0 000000 00000000
W 38003020 DEADBEEF 0 000000 00000000
R 38004000 00000000 0 000000 00000000
R 37FFFFFC 00000000 0 000000 00000000
R 00000000 00000000 0 000000 00000000
R 38003014 00000000 0 000000 00000000
R 38000C1C 00000000 4 000C1C 11110C1C

//--- tests/tb_fir_bus_interconnect.sv
module tb_fir_bus_interconnect;

  import wb_pkg::*;
  import fir_map_pkg::*;

  localparam logic [31:0] endflag_value   = 32'hE0F1_0003;
  localparam int          cycles_per_line = 20;

  logic        clk;
  logic        rst;
  wb_req_t     cpu_req;
  wb_rsp_t     cpu_rsp;
  wb_req_t     dma1_req;
  wb_rsp_t     dma1_rsp;
  wb_req_t     dma2_req;
  wb_rsp_t     dma2_rsp;
  logic [31:0] endflag;
  mem_addr_t   mem_addr;
  logic        mem_rw;
  logic [31:0] mem_wdata;
  logic        mem_in_valid;
  logic        mem_busy;
  logic        mem_out_valid;
  logic [31:0] mem_rdata;

  logic [7:0]  g_op[$];
  logic [31:0] g_adr[$];
  logic [31:0] g_wdata[$];
  logic [31:0] g_tgt[$];
  logic [31:0] g_maddr[$];
  logic [31:0] g_rdata[$];
  int          n_lines = 0;
  logic        loaded = 1'b0;

  logic [31:0] mem_store [0:63]; // controller model storage
  logic [31:0] rng = 32'd74;
  logic [2:0]  rd_left;
  logic [2:0]  rd_delay;
  logic [5:0]  rd_idx;
  logic [1:0]  busy_left;
  logic [1:0]  dma1_age;
  logic [1:0]  dma2_age;
  logic [31:0] dma1_echo;
  logic [31:0] dma2_echo;

  fir_bus_interconnect u_dut (
    .clk           (clk),
    .rst           (rst),
    .cpu_req       (cpu_req),
    .cpu_rsp       (cpu_rsp),
    .dma1_req      (dma1_req),
    .dma1_rsp      (dma1_rsp),
    .dma2_req      (dma2_req),
    .dma2_rsp      (dma2_rsp),
    .endflag       (endflag),
    .mem_addr      (mem_addr),
    .mem_rw        (mem_rw),
    .mem_wdata     (mem_wdata),
    .mem_in_valid  (mem_in_valid),
    .mem_busy      (mem_busy),
    .mem_out_valid (mem_out_valid),
    .mem_rdata     (mem_rdata)
  );

  bind fir_bus_interconnect fir_bus_properties u_props (
    .clk           (clk),
    .rst           (rst),
    .ram_req       (ram_req),
    .ram_rsp       (ram_rsp),
    .dma1_req      (dma1_req),
    .dma2_req      (dma2_req),
    .mem_rw        (mem_rw),
    .mem_in_valid  (mem_in_valid),
    .mem_busy      (mem_busy),
    .mem_out_valid (mem_out_valid)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // model word index from the bank bits and the low word bits
  function automatic logic [5:0] store_index(input mem_addr_t a);
    return {a[9:8], a[5:2]};
  endfunction

  // outward ports a target may touch as {mem, dma2, dma1}
  function automatic logic [2:0] port_mask(input logic [31:0] tgt);
    case (target_e'(tgt[2:0]))
      t_dma1:  return 3'b001;
      t_dma2:  return 3'b010;
      t_ram:   return 3'b100;
      default: return 3'b000;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [71:0] got, input logic [71:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, exp);
      $display("TEST FAILED");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // memory controller model samples requests on the rising edge
  always @(posedge clk) begin
    if (rst) begin
      rd_left <= 3'd0;
    end else if (mem_in_valid && !mem_busy && !mem_rw) begin
      rd_left <= rd_delay;
      rd_idx  <= store_index(mem_addr);
    end else if (rd_left != 3'd0) begin
      rd_left <= rd_left - 3'd1;
    end
    if (!rst && mem_in_valid && !mem_busy && mem_rw) begin
      mem_store[store_index(mem_addr)] <= mem_wdata;
    end
  end

  always @(negedge clk) begin
    rng = xorshift32(rng);
    if (rst) begin
      mem_busy      <= 1'b0;
      mem_out_valid <= 1'b0;
      mem_rdata     <= 32'h0;
      busy_left     <= 2'd0;
    end else begin
      mem_out_valid <= (rd_left == 3'd1);
      mem_rdata     <= (rd_left == 3'd1) ? mem_store[rd_idx] : 32'h0;
      if (busy_left != 2'd0) begin
        mem_busy  <= 1'b1;
        busy_left <= busy_left - 2'd1;
      end else if (rng[1:0] == 2'b00) begin // busy burst of 1 or 2 cycles
        mem_busy  <= 1'b1;
        busy_left <= {1'b0, rng[2]};
      end else begin
        mem_busy <= 1'b0;
      end
    end
    rd_delay <= {1'b0, rng[5:4]} + 3'd1;
  end

  // dma register ports ack one cycle late with an echo of the address
  always @(posedge clk) begin
    if (rst || !(dma1_req.cyc && dma1_req.stb)) begin
      dma1_age <= 2'd0;
    end else if (dma1_age != 2'd3) begin
      dma1_age <= dma1_age + 2'd1;
    end
    if (rst || !(dma2_req.cyc && dma2_req.stb)) begin
      dma2_age <= 2'd0;
    end else if (dma2_age != 2'd3) begin
      dma2_age <= dma2_age + 2'd1;
    end
    dma1_echo <= {~dma1_req.adr[31:24], dma1_req.adr[23:0]};
    dma2_echo <= {~dma2_req.adr[31:24], dma2_req.adr[23:0]};
  end

  always @(negedge clk) begin
    dma1_rsp.ack <= (dma1_age == 2'd1);
    dma1_rsp.dat <= dma1_echo;
    dma2_rsp.ack <= (dma2_age == 2'd1);
    dma2_rsp.dat <= dma2_echo;
  end

  // nothing may move while the cpu bus is idle
  always @(posedge clk) begin
    if (!rst && !cpu_req.cyc) begin
      check_value("idle mem_in_valid", mem_in_valid, 1'b0);
      check_value("idle dma1_req.cyc", dma1_req.cyc, 1'b0);
      check_value("idle dma2_req.cyc", dma2_req.cyc, 1'b0);
      check_value("idle cpu_rsp.ack", cpu_rsp.ack, 1'b0);
    end
  end

  // a bound assertion failure ends the run
  always @(posedge clk) begin
    if (u_dut.u_props.fail_total != 0) begin
      $display("a bound assertion failed");
      $display("TEST FAILED");
      $fatal(1, "assertion failure");
    end
  end

  task automatic run_access(input int idx);
    logic        is_wr;
    logic [2:0]  seen;
    logic        got_ack;
    logic [31:0] rdata;
    logic [31:0] tgt;
    int          cycles;
    int          accepts;
    is_wr   = (g_op[idx] == "W");
    tgt     = g_tgt[idx];
    seen    = 3'b000;
    got_ack = 1'b0;
    rdata   = 32'h0;
    cycles  = 0;
    accepts = 0;
    @(negedge clk);
    cpu_req.cyc = 1'b1;
    cpu_req.stb = 1'b1;
    cpu_req.we  = is_wr;
    cpu_req.sel = 4'hF;
    cpu_req.adr = g_adr[idx];
    cpu_req.dat = g_wdata[idx];
    while (!got_ack) begin
      @(posedge clk);
      if (dma1_req.cyc && dma1_req.stb) begin
        seen[0] = 1'b1;
        check_value("dma1_req", dma1_req, cpu_req);
      end
      if (dma2_req.cyc && dma2_req.stb) begin
        seen[1] = 1'b1;
        check_value("dma2_req", dma2_req, cpu_req);
      end
      if (mem_in_valid) begin
        seen[2] = 1'b1;
        check_value("mem_addr", mem_addr, g_maddr[idx]);
        check_value("mem_rw", mem_rw, is_wr);
        if (is_wr) begin
          check_value("mem_wdata", mem_wdata, g_wdata[idx]);
        end
        if (!mem_busy) begin
          accepts++;
        end else if (is_wr) begin
          check_value("cpu_rsp.ack under busy", cpu_rsp.ack, 1'b0);
        end
      end
      if (cpu_rsp.ack) begin
        got_ack = 1'b1;
        rdata   = cpu_rsp.dat;
      end else begin
        cycles++;
      end
    end
    @(negedge clk);
    cpu_req = '0;
    check_value("port_mask", seen, port_mask(tgt));
    if (target_e'(tgt[2:0]) == t_ram) begin
      check_value("mem_accepts", accepts, 1);
    end
    if (!is_wr || tgt == 32'(t_status) || tgt == 32'(t_none)) begin
      check_value("cpu_rsp.dat", rdata, g_rdata[idx]);
    end
    if (tgt == 32'(t_status) || tgt == 32'(t_none)) begin
      check_value("ack_cycle", cycles, 0);
    end else if (tgt == 32'(t_dma1) || tgt == 32'(t_dma2)) begin
      check_value("ack_cycle", cycles, 1);
    end
  endtask

  initial begin
    int          fd;
    int          r;
    int          ch;
    logic [7:0]  c;
    logic [31:0] f_adr;
    logic [31:0] f_wdata;
    logic [31:0] f_tgt;
    logic [31:0] f_maddr;
    logic [31:0] f_rdata;
    clk      = 1'b0;
    rst      = 1'b1;
    cpu_req  = '0;
    dma1_rsp = '0;
    dma2_rsp = '0;
    endflag  = endflag_value;
    mem_busy      = 1'b0;
    mem_out_valid = 1'b0;
    mem_rdata     = 32'h0;
    for (int i = 0; i < 64; i++) begin
      mem_store[i] = 32'hF111_0000 + i;
    end
    fd = $fopen("tests/fir_bus_golden.txt", "r");
    if (fd == 0) begin
      $display("could not open tests/fir_bus_golden.txt");
      $display("TEST FAILED");
      $fatal(1, "no stimulus");
    end
    r = $fscanf(fd, " %c", c);
    while (r == 1) begin
      if (c == "#") begin
        ch = $fgetc(fd);
        while (ch != "\n" && ch != -1) begin
          ch = $fgetc(fd);
        end
      end else begin
        r = $fscanf(fd, " %h %h %h %h %h", f_adr, f_wdata, f_tgt, f_maddr, f_rdata);
        if (r != 5 || (c != "W" && c != "R")) begin
          $display("malformed line %0d in the golden file", g_op.size() + 1);
          $display("TEST FAILED");
          $fatal(1, "bad stimulus");
        end
        g_op.push_back(c);
        g_adr.push_back(f_adr);
        g_wdata.push_back(f_wdata);
        g_tgt.push_back(f_tgt);
        g_maddr.push_back(f_maddr);
        g_rdata.push_back(f_rdata);
      end
      r = $fscanf(fd, " %c", c);
    end
    $fclose(fd);
    n_lines = g_op.size();
    loaded  = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int i = 0; i < n_lines; i++) begin
      run_access(i);
    end
    repeat (2) @(posedge clk);
    if (n_lines > 0 && u_dut.u_props.fail_total == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("no transactions were run or a bound assertion failed");
      $display("TEST FAILED");
      $fatal(1, "run failed");
    end
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (n_lines * cycles_per_line + 2) @(posedge clk);
    $display("watchdog expired, a bus access never completed");
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- tests/fir_bus_properties.sv
module fir_bus_properties (
  input logic            clk,
  input logic            rst,
  input wb_pkg::wb_req_t ram_req,
  input wb_pkg::wb_rsp_t ram_rsp,
  input wb_pkg::wb_req_t dma1_req,
  input wb_pkg::wb_req_t dma2_req,
  input logic            mem_rw,
  input logic            mem_in_valid,
  input logic            mem_busy,
  input logic            mem_out_valid
);

  int   n_one_target = 0;
  int   n_read_gap   = 0;
  int   n_write_busy = 0;
  int   fail_total;
  logic ram_act;
  logic dma1_act;
  logic dma2_act;
  logic rd_wait; // read accepted and result not back yet

  assign ram_act    = ram_req.cyc & ram_req.stb;
  assign dma1_act   = dma1_req.cyc & dma1_req.stb;
  assign dma2_act   = dma2_req.cyc & dma2_req.stb;
  assign fail_total = n_one_target + n_read_gap + n_write_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_wait <= 1'b0;
    end else if (mem_in_valid && !mem_rw && !mem_busy) begin
      rd_wait <= 1'b1;
    end else if (mem_out_valid) begin
      rd_wait <= 1'b0;
    end
  end

  a_one_target: assert property (@(posedge clk) disable iff (rst)
    $onehot0({ram_act, dma1_act, dma2_act}))
    else begin
      n_one_target++;
      $error("more than one target port active");
    end

  a_read_gap: assert property (@(posedge clk) disable iff (rst)
    rd_wait |-> !mem_in_valid)
    else begin
      n_read_gap++;
      $error("mem_in_valid high while a read is outstanding");
    end

  a_write_busy: assert property (@(posedge clk) disable iff (rst)
    (ram_act && ram_req.we && mem_busy) |-> !ram_rsp.ack)
    else begin
      n_write_busy++;
      $error("memory write acked while mem_busy is high");
    end

endmodule

//--- hdl/fir_bus_interconnect.sv
module fir_bus_interconnect (
  input  logic                        clk,
  input  logic                        rst,

  input  wb_pkg::wb_req_t             cpu_req,
  output wb_pkg::wb_rsp_t             cpu_rsp,

  output wb_pkg::wb_req_t             dma1_req,
  input  wb_pkg::wb_rsp_t             dma1_rsp,
  output wb_pkg::wb_req_t             dma2_req,
  input  wb_pkg::wb_rsp_t             dma2_rsp,

  input  logic [wb_pkg::wb_dat_w-1:0] endflag,

  output fir_map_pkg::mem_addr_t      mem_addr,
  output logic                        mem_rw,
  output logic [wb_pkg::wb_dat_w-1:0] mem_wdata,
  output logic                        mem_in_valid,
  input  logic                        mem_busy,
  input  logic                        mem_out_valid,
  input  logic [wb_pkg::wb_dat_w-1:0] mem_rdata
);

  import wb_pkg::*;

  wb_req_t ram_req;
  wb_rsp_t ram_rsp;

  cpu_addr_router u_router (
    .cpu_req  (cpu_req),
    .cpu_rsp  (cpu_rsp),
    .dma1_req (dma1_req),
    .dma1_rsp (dma1_rsp),
    .dma2_req (dma2_req),
    .dma2_rsp (dma2_rsp),
    .ram_req  (ram_req),
    .ram_rsp  (ram_rsp),
    .endflag  (endflag)
  );

  mem_req_bridge u_mem (
    .clk           (clk),
    .rst           (rst),
    .ram_req       (ram_req),
    .ram_rsp       (ram_rsp),
    .mem_addr      (mem_addr),
    .mem_rw        (mem_rw),
    .mem_wdata     (mem_wdata),
    .mem_in_valid  (mem_in_valid),
    .mem_busy      (mem_busy),
    .mem_out_valid (mem_out_valid),
    .mem_rdata     (mem_rdata)
  );

endmodule

//--- hdl/cpu_addr_router.sv
module cpu_addr_router (
  input  wb_pkg::wb_req_t             cpu_req,
  output wb_pkg::wb_rsp_t             cpu_rsp,

  output wb_pkg::wb_req_t             dma1_req,
  input  wb_pkg::wb_rsp_t             dma1_rsp,

  output wb_pkg::wb_req_t             dma2_req,
  input  wb_pkg::wb_rsp_t             dma2_rsp,

  output wb_pkg::wb_req_t             ram_req,
  input  wb_pkg::wb_rsp_t             ram_rsp,

  input  logic [wb_pkg::wb_dat_w-1:0] endflag
);

  import fir_map_pkg::*;

  target_e target;
  logic    active;

  assign active = cpu_req.cyc & cpu_req.stb;

  // one target per address with registers checked first
  always_comb begin
    if (cpu_req.adr == dma1_x_adr0 || cpu_req.adr == dma1_x_adr1) begin
      target = t_dma1;
    end else if (cpu_req.adr == dma2_adr_reg || cpu_req.adr == dma2_len_reg) begin
      target = t_dma2;
    end else if (cpu_req.adr == status_adr) begin
      target = t_status;
    end else if (cpu_req.adr >= code_base && cpu_req.adr < mmio_base) begin
      target = t_ram;
    end else begin
      target = t_none;
    end
  end

  // unselected ports see an idle bus
  always_comb begin
    dma1_req = '0;
    dma2_req = '0;
    ram_req  = '0;
    case (target)
      t_dma1: dma1_req = cpu_req;
      t_dma2: dma2_req = cpu_req;
      t_ram:  ram_req  = cpu_req;
      default: begin
      end
    endcase
  end

  // response mux
  always_comb begin
    cpu_rsp = '0;
    case (target)
      t_dma1: begin
        cpu_rsp = dma1_rsp;
      end
      t_dma2: begin
        cpu_rsp = dma2_rsp;
      end
      t_ram: begin
        cpu_rsp = ram_rsp;
      end
      t_status: begin
        cpu_rsp.ack = active; // answered in the same cycle
        if (active && !cpu_req.we) begin
          cpu_rsp.dat = endflag;
        end
      end
      default: begin
        // unmapped addresses ack with zero data and drop writes
        cpu_rsp.ack = active;
      end
    endcase
  end

endmodule

//--- hdl/mem_req_bridge.sv
module mem_req_bridge (
  input  logic                        clk,
  input  logic                        rst,

  input  wb_pkg::wb_req_t             ram_req,
  output wb_pkg::wb_rsp_t             ram_rsp,

  output fir_map_pkg::mem_addr_t      mem_addr,
  output logic                        mem_rw,
  output logic [wb_pkg::wb_dat_w-1:0] mem_wdata,
  output logic                        mem_in_valid,
  input  logic                        mem_busy,
  input  logic                        mem_out_valid,
  input  logic [wb_pkg::wb_dat_w-1:0] mem_rdata
);

  logic active;
  logic rd_pending; // read accepted and waiting for out_valid
  logic rd_accept;

  assign active = ram_req.cyc & ram_req.stb;

  mem_region_map u_map (
    .adr      (ram_req.adr),
    .region   (),
    .mem_addr (mem_addr)
  );

  // writes hold the request; reads present it until accepted once
  assign mem_in_valid = active & (ram_req.we | ~rd_pending);
  assign rd_accept    = active & ~ram_req.we & ~rd_pending & ~mem_busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pending <= 1'b0;
    end else if (rd_accept) begin
      rd_pending <= 1'b1;
    end else if (mem_out_valid) begin
      rd_pending <= 1'b0;
    end
  end

  assign mem_rw    = ram_req.we;
  assign mem_wdata = ram_req.dat;

  always_comb begin
    if (ram_req.we) begin
      ram_rsp.ack = active & ~mem_busy; // write done once the controller takes it
    end else begin
      ram_rsp.ack = active & rd_pending & mem_out_valid;
    end
    ram_rsp.dat = mem_rdata;
  end

endmodule

//--- hdl/mem_region_map.sv
module mem_region_map (
  input  logic [wb_pkg::wb_adr_w-1:0] adr,
  output fir_map_pkg::region_e        region,
  output fir_map_pkg::mem_addr_t      mem_addr
);

  import fir_map_pkg::*;

  logic [1:0] bank;

  // bits 13:12 tell the 4 KiB regions apart inside the window
  always_comb begin
    case (adr[13:12])
      code_base[13:12]:   region = r_code;
      input_base[13:12]:  region = r_input;
      output_base[13:12]: region = r_output;
      default:            region = r_code; // not reachable through the router
    endcase
  end

  always_comb begin
    case (region)
      r_input:  bank = bank_input;
      r_output: bank = bank_output;
      default:  bank = bank_code;
    endcase
  end

  // bank code replaces bits 9:8
  assign mem_addr = {adr[22:10], bank, adr[7:0]};

endmodule

//--- hdl/fir_map_pkg.sv
package fir_map_pkg;

  localparam int mem_addr_w = 23; // memory controller user address

  // 4 KiB memory regions
  localparam logic [31:0] code_base   = 32'h3800_0000;
  localparam logic [31:0] input_base  = 32'h3800_1000;
  localparam logic [31:0] output_base = 32'h3800_2000;
  localparam logic [31:0] mmio_base   = 32'h3800_3000; // end of memory window

  // register window
  localparam logic [31:0] dma1_x_adr0  = 32'h3800_3000; // input samples
  localparam logic [31:0] dma1_x_adr1  = 32'h3800_3004;
  localparam logic [31:0] dma2_adr_reg = 32'h3800_3008;
  localparam logic [31:0] dma2_len_reg = 32'h3800_300C;
  localparam logic [31:0] status_adr   = 32'h3800_3010; // endflag

  // fixed bank per region in controller address bits 9:8
  localparam logic [1:0] bank_code   = 2'b00;
  localparam logic [1:0] bank_input  = 2'b01;
  localparam logic [1:0] bank_output = 2'b10;

  typedef enum logic [2:0] {
    t_none,
    t_dma1,
    t_dma2,
    t_status,
    t_ram
  } target_e;

  typedef enum logic [1:0] {
    r_code,
    r_input,
    r_output
  } region_e;

  typedef logic [mem_addr_w-1:0] mem_addr_t;

endpackage

//--- hdl/wb_pkg.sv
package wb_pkg;

  localparam int wb_adr_w = 32;
  localparam int wb_dat_w = 32;
  localparam int wb_sel_w = 4;

  // master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [wb_sel_w-1:0] sel;
    logic [wb_adr_w-1:0] adr;
    logic [wb_dat_w-1:0] dat;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                ack;
    logic [wb_dat_w-1:0] dat;
  } wb_rsp_t;

endpackage
